/* Bender.yml */
package:
  name: pitaya_analog

sources:
  - analog_pkg.sv
  - sys_bus_pkg.sv
  - sys_bus_decoder.sv
  - hk_regs.sv
  - adc_capture.sv
  - dac_drive.sv
  - pitaya_analog_top.sv
  - target: test
    files:
      - tb_pitaya_top.sv

/* adc_capture.sv */
`timescale 1ns/10ps
// ADC capture
// registers both raw channels, turns the neg-slope code into signed
// samples and optionally swaps in the DAC values for digital loopback
module adc_capture (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  analog_pkg::raw_t       adc_dat_a_i,
  input  analog_pkg::raw_t       adc_dat_b_i,
  input  logic                   digital_loop_i,
  input  analog_pkg::chan_pair_t dac_i,
  output analog_pkg::chan_pair_t samples_o
);

  analog_pkg::raw_t       raw_a_q;    // pin registers
  analog_pkg::raw_t       raw_b_q;
  analog_pkg::chan_pair_t adc_smp;    // converted pins
  analog_pkg::chan_pair_t smp_d;      // after loop mux
  analog_pkg::chan_pair_t samples_q;

  //////////////////////////////////////////////////////////////
  // raw input registers, edge N
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= analog_pkg::RAW_ZERO;  // reads back as 0
      raw_b_q <= analog_pkg::RAW_ZERO;
    end
    else
    begin
      raw_a_q <= adc_dat_a_i;
      raw_b_q <= adc_dat_b_i;
    end
  end

  // neg-slope to two's complement
  assign adc_smp.a = analog_pkg::raw_to_sample(raw_a_q);
  assign adc_smp.b = analog_pkg::raw_to_sample(raw_b_q);

  assign smp_d = digital_loop_i ? dac_i : adc_smp;  // loopback replaces both

  //////////////////////////////////////////////////////////////
  // sample register, edge N+1
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      samples_q <= '0;
    end
    else
    begin
      samples_q <= smp_d;
    end
  end

  assign samples_o = samples_q;

endmodule

/* analog_pkg.sv */
// analog sample package
// widths, pin codes and sample types for the two ADC/DAC channels,
// plus the negative-slope code conversion used at both ends
package analog_pkg;

  localparam int SAMPLE_W = 14;  // ADC and DAC resolution

  typedef logic        [SAMPLE_W-1:0] raw_t;     // unsigned neg-slope pin code
  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement sample

  // both channels side by side
  typedef struct packed {
    sample_t a;  // channel a, upper half
    sample_t b;  // channel b
  } chan_pair_t;

  // pin code of a zero sample
  localparam raw_t RAW_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};

  //////////////////////////////////////////////////////////////
  // conversion, keep msb and flip the lower bits
  //////////////////////////////////////////////////////////////

  function automatic sample_t raw_to_sample(input raw_t raw);
    return sample_t'({raw[SAMPLE_W-1], ~raw[SAMPLE_W-2:0]});
  endfunction

  function automatic raw_t sample_to_raw(input sample_t smp);
    return raw_t'({smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]});  // same rule backwards
  endfunction

endpackage

/* dac_drive.sv */
`timescale 1ns/10ps
// DAC drive
// per channel source select (adc sample or dc level), signed DAC
// register, then neg-slope formatting into the pin registers
module dac_drive (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  analog_pkg::chan_pair_t samples_i,
  input  sys_bus_pkg::hk_cfg_t   cfg_i,
  output analog_pkg::chan_pair_t dac_o,
  output analog_pkg::raw_t       dac_dat_a_o,
  output analog_pkg::raw_t       dac_dat_b_o
);

  analog_pkg::chan_pair_t dac_d;    // selected source
  analog_pkg::chan_pair_t dac_q;    // signed, edge N+2
  analog_pkg::raw_t       pin_a_q;  // formatted, edge N+3
  analog_pkg::raw_t       pin_b_q;

  // stands in for the dsp block
  assign dac_d.a = cfg_i.src_dc_a ? cfg_i.dc_level.a : samples_i.a;
  assign dac_d.b = cfg_i.src_dc_b ? cfg_i.dc_level.b : samples_i.b;

  //////////////////////////////////////////////////////////////
  // signed dac register and pin registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_q   <= '0;
      pin_a_q <= analog_pkg::RAW_ZERO;  // formatted zero, 14'h1FFF
      pin_b_q <= analog_pkg::RAW_ZERO;
    end
    else
    begin
      dac_q   <= dac_d;
      pin_a_q <= analog_pkg::sample_to_raw(dac_q.a);
      pin_b_q <= analog_pkg::sample_to_raw(dac_q.b);
    end
  end

  assign dac_o       = dac_q;  // also feeds loopback
  assign dac_dat_a_o = pin_a_q;
  assign dac_dat_b_o = pin_b_q;

  // pins stay defined through the whole capture and drive chain
  a_pins_known : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown({dac_dat_a_o, dac_dat_b_o})
  );

endmodule

/* hk_regs.sv */
`timescale 1ns/10ps
// housekeeping register bank, region 0
// id, control bits, LEDs and dc levels, plus readback of the live samples
module hk_regs (
  input  logic                   adc_clk,
  input  logic                   rst_n_i,
  input  sys_bus_pkg::sys_req_t  req_i,
  output sys_bus_pkg::sys_rsp_t  rsp_o,
  input  analog_pkg::chan_pair_t samples_i,
  output sys_bus_pkg::hk_cfg_t   cfg_o,
  output logic [7:0]             led_o
);

  sys_bus_pkg::offs_t              offs;     // register offset
  sys_bus_pkg::hk_cfg_t            cfg_q;
  logic [7:0]                      led_q;
  logic [sys_bus_pkg::DATA_W-1:0]  rd_mux;
  logic [sys_bus_pkg::DATA_W-1:0]  rdata_q;
  logic [15:0]                     adc_a16;  // samples widened for REG_ADC
  logic [15:0]                     adc_b16;
  logic                            hit;      // defined offset
  logic                            ack_q;
  logic                            err_q;

  // signed level to a full bus word
  function automatic logic [sys_bus_pkg::DATA_W-1:0] sext32(input analog_pkg::sample_t s);
    return {{(sys_bus_pkg::DATA_W-analog_pkg::SAMPLE_W){s[analog_pkg::SAMPLE_W-1]}}, s};
  endfunction

  assign offs    = req_i.addr[sys_bus_pkg::REGION_LSB-1:0];
  assign adc_a16 = {{(16-analog_pkg::SAMPLE_W){samples_i.a[analog_pkg::SAMPLE_W-1]}},
                    samples_i.a};
  assign adc_b16 = {{(16-analog_pkg::SAMPLE_W){samples_i.b[analog_pkg::SAMPLE_W-1]}},
                    samples_i.b};

  //////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_mux = '0;
    case (offs)
      sys_bus_pkg::REG_ID   : rd_mux = sys_bus_pkg::HK_ID;
      sys_bus_pkg::REG_CTRL : rd_mux[2:0] = {cfg_q.src_dc_b, cfg_q.src_dc_a, cfg_q.digital_loop};
      sys_bus_pkg::REG_LED  : rd_mux[7:0] = led_q;
      sys_bus_pkg::REG_DC_A : rd_mux = sext32(cfg_q.dc_level.a);
      sys_bus_pkg::REG_DC_B : rd_mux = sext32(cfg_q.dc_level.b);
      sys_bus_pkg::REG_ADC  : rd_mux = {adc_b16, adc_a16};  // b high, a low
      default               : hit = 1'b0;                   // err, data stays 0
    endcase
  end

  //////////////////////////////////////////////////////////////
  // write and handshake
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cfg_q <= '0;  // no loop, adc source
      led_q <= '0;
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;           // one cycle after strobe
      err_q <= (req_i.wen | req_i.ren) & ~hit;
      if (req_i.wen)
      begin
        case (offs)
          sys_bus_pkg::REG_CTRL :
          begin
            cfg_q.digital_loop <= req_i.wdata[0];
            cfg_q.src_dc_a     <= req_i.wdata[1];
            cfg_q.src_dc_b     <= req_i.wdata[2];
          end
          sys_bus_pkg::REG_LED  : led_q <= req_i.wdata[7:0];
          sys_bus_pkg::REG_DC_A : cfg_q.dc_level.a <= req_i.wdata[analog_pkg::SAMPLE_W-1:0];
          sys_bus_pkg::REG_DC_B : cfg_q.dc_level.b <= req_i.wdata[analog_pkg::SAMPLE_W-1:0];
          default               : ;  // ro or undefined, ignored
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= req_i.ren ? rd_mux : '0;  // lines up with ack
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = err_q;
  assign cfg_o       = cfg_q;
  assign led_o       = led_q;

  // master never issues read and write in one cycle
  a_no_rw_overlap : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !(req_i.wen && req_i.ren)
  );

endmodule

/* pitaya_analog_top.sv */
`timescale 1ns/10ps
// analog front end top
// bus decoder and housekeeping beside the ADC capture to DAC drive path
module pitaya_analog_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  analog_pkg::raw_t      adc_dat_a_i,
  input  analog_pkg::raw_t      adc_dat_b_i,
  input  sys_bus_pkg::sys_req_t sys_req_i,
  output sys_bus_pkg::sys_rsp_t sys_rsp_o,
  output analog_pkg::raw_t      dac_dat_a_o,
  output analog_pkg::raw_t      dac_dat_b_o,
  output logic [7:0]            led_o
);

  sys_bus_pkg::sys_req_t  hk_req;   // region 0 request
  sys_bus_pkg::sys_rsp_t  hk_rsp;
  sys_bus_pkg::hk_cfg_t   hk_cfg;   // loop, selects, dc levels
  analog_pkg::chan_pair_t samples;  // capture out
  analog_pkg::chan_pair_t dac;      // signed dac values, loopback

  sys_bus_decoder i_dec (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .req_i    (sys_req_i),
    .rsp_o    (sys_rsp_o),
    .hk_req_o (hk_req),
    .hk_rsp_i (hk_rsp)
  );

  hk_regs i_hk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .samples_i (samples),   // live readback
    .cfg_o     (hk_cfg),
    .led_o     (led_o)
  );

  adc_capture i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (hk_cfg.digital_loop),
    .dac_i          (dac),
    .samples_o      (samples)
  );

  dac_drive i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .samples_i   (samples),
    .cfg_i       (hk_cfg),
    .dac_o       (dac),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* sys_bus_decoder.sv */
`timescale 1ns/10ps
// system bus decoder
// splits the bus into eight regions by addr[22:20], gates the strobes
// to the selected region and returns that region's response
module sys_bus_decoder (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  sys_bus_pkg::sys_req_t req_i,
  output sys_bus_pkg::sys_rsp_t rsp_o,
  output sys_bus_pkg::sys_req_t hk_req_o,
  input  sys_bus_pkg::sys_rsp_t hk_rsp_i
);

  logic [sys_bus_pkg::REGION_W-1:0]  region;  // selected region
  logic [sys_bus_pkg::N_REGIONS-1:0] cs;      // one-hot select
  logic [sys_bus_pkg::N_REGIONS-1:0] wen_r;
  logic [sys_bus_pkg::N_REGIONS-1:0] ren_r;
  sys_bus_pkg::sys_rsp_t             rsp_r [sys_bus_pkg::N_REGIONS];

  assign region = req_i.addr[sys_bus_pkg::REGION_LSB +: sys_bus_pkg::REGION_W];
  assign cs     = {{(sys_bus_pkg::N_REGIONS-1){1'b0}}, 1'b1} << region;

  assign wen_r = cs & {sys_bus_pkg::N_REGIONS{req_i.wen}};  // strobe only the hit
  assign ren_r = cs & {sys_bus_pkg::N_REGIONS{req_i.ren}};

  //////////////////////////////////////////////////////////////
  // region slaves
  //////////////////////////////////////////////////////////////

  for (genvar i = 0; i < sys_bus_pkg::N_REGIONS; i++)
  begin : g_region
    if (i == sys_bus_pkg::HK_REGION)
    begin : g_hk
      assign rsp_r[i] = hk_rsp_i;
    end
    else
    begin : g_unused
      // empty region, acks at once with zero data
      assign rsp_r[i].rdata = '0;
      assign rsp_r[i].ack   = wen_r[i] | ren_r[i];
      assign rsp_r[i].err   = 1'b0;
    end
  end

  always_comb
  begin
    hk_req_o     = req_i;  // addr and wdata go through
    hk_req_o.wen = wen_r[sys_bus_pkg::HK_REGION];
    hk_req_o.ren = ren_r[sys_bus_pkg::HK_REGION];
  end

  assign rsp_o = rsp_r[region];  // master holds addr until ack

  // no slave acks later than one cycle after its strobe
  a_ack_after_strobe : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    rsp_o.ack |-> (req_i.wen || req_i.ren || $past(req_i.wen || req_i.ren))
  );

endmodule

/* sys_bus_pkg.sv */
// system bus package
// request and response words, region split, housekeeping register map
// and the configuration that housekeeping hands to the datapath
package sys_bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int N_REGIONS  = 8;
  localparam int REGION_LSB = 20;                  // region in addr[22:20]
  localparam int REGION_W   = $clog2(N_REGIONS);

  // master to slave, strobes are single cycle
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;   // always full word
    logic              wen;     // write strobe
    logic              ren;     // read strobe
  } sys_req_t;

  // slave to master
  typedef struct packed {
    logic [DATA_W-1:0] rdata;   // valid with ack
    logic              ack;
    logic              err;     // undefined offset
  } sys_rsp_t;

  //////////////////////////////////////////////////////////////
  // housekeeping map
  //////////////////////////////////////////////////////////////

  localparam int HK_REGION = 0;

  typedef logic [REGION_LSB-1:0] offs_t;  // offset inside a region

  localparam offs_t REG_ID   = 'h00;  // ro
  localparam offs_t REG_CTRL = 'h04;  // loop and source selects
  localparam offs_t REG_LED  = 'h08;
  localparam offs_t REG_DC_A = 'h0C;
  localparam offs_t REG_DC_B = 'h10;
  localparam offs_t REG_ADC  = 'h14;  // ro, live samples

  localparam logic [DATA_W-1:0] HK_ID = 32'hA7C0_0E14;

  // control bits and dc levels towards capture and dac drive
  typedef struct packed {
    logic                   digital_loop;  // dac values back into adc path
    logic                   src_dc_a;      // dac a from dc level
    logic                   src_dc_b;      // dac b from dc level
    analog_pkg::chan_pair_t dc_level;
  } hk_cfg_t;

endpackage

/* tb.f */
analog_pkg.sv
sys_bus_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
adc_capture.sv
dac_drive.sv
pitaya_analog_top.sv
tb_pitaya_top.sv

/* tb_pitaya_top.sv */
`timescale 1ns/10ps
// testbench for the analog front end top
// random pass-through, housekeeping registers, dc source, loopback and decode
module tb_pitaya_top;

  localparam int          BUS_TIMEOUT  = 16;        // cycles to wait for ack
  localparam int          POLL_TIMEOUT = 20;
  localparam logic [13:0] DC_A         = 14'h2A5C;  // negative level
  localparam logic [13:0] DC_B         = 14'h0123;

  logic                  adc_clk;
  logic                  rst_n;
  analog_pkg::raw_t      adc_a;     // adc pins
  analog_pkg::raw_t      adc_b;
  analog_pkg::raw_t      dac_a;     // dac pins
  analog_pkg::raw_t      dac_b;
  logic [7:0]            led;
  sys_bus_pkg::sys_req_t sys_req;
  sys_bus_pkg::sys_rsp_t sys_rsp;
  sys_bus_pkg::sys_rsp_t rsp;       // last bus response
  analog_pkg::raw_t      hist_a [4];  // input history with [3] the oldest
  analog_pkg::raw_t      hist_b [4];
  analog_pkg::raw_t      dc_pin_a;  // expected pin a while on dc
  logic                  chk_a;     // per channel checker enables
  logic                  chk_b;
  logic                  dc_sel_a;
  logic [31:0]           rng;
  logic [31:0]           adc_exp;
  int                    err_val;
  int                    err_to;
  int                    n;

  pitaya_analog_top uut (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  always #5 adc_clk = ~adc_clk;  // 100 MHz

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // top bit kept and lower 13 inverted in both directions
  function automatic analog_pkg::raw_t neg_slope(input logic [13:0] w);
    return {w[13], ~w[12:0]};
  endfunction

  // adc conversion then dac formatting
  function automatic analog_pkg::raw_t path_model(input analog_pkg::raw_t w);
    return neg_slope(neg_slope(w));
  endfunction

  function automatic logic [31:0] widen_level(input logic [13:0] v);
    return {{18{v[13]}}, v};  // sign-extended level
  endfunction

  function automatic sys_bus_pkg::sys_rsp_t expect_rsp(input logic [31:0] d, input logic e);
    sys_bus_pkg::sys_rsp_t r;
    r.rdata = d;
    r.ack   = 1'b1;
    r.err   = e;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_pin(input string name, input analog_pkg::raw_t got,
                           input analog_pkg::raw_t exp);
    if (got !== exp)
    begin
      err_val++;
      $display("error %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_rsp(input string name, input sys_bus_pkg::sys_rsp_t got,
                           input sys_bus_pkg::sys_rsp_t exp);
    if (got !== exp)
    begin
      err_val++;
      $display("error sys_rsp_o %s: rdata %h ack %h err %h, expected %h %h %h",
               name, got.rdata, got.ack, got.err, exp.rdata, exp.ack, exp.err);
    end
  endtask

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      err_val++;
      $display("error led_o: got %h expected %h", got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus and stimulus
  ////////////////////////////////////////////////////////////

  task automatic transfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic we, output sys_bus_pkg::sys_rsp_t r);
    int   cnt;
    logic got;
    cnt = 0;
    got = 1'b0;
    r   = '0;
    @(posedge adc_clk);
    sys_req.addr  <= addr;  // held until the next transfer
    sys_req.wdata <= wdata;
    sys_req.wen   <= we;
    sys_req.ren   <= !we;
    @(negedge adc_clk);
    if (sys_rsp.ack)
    begin
      got = 1'b1;  // unused regions ack in the strobe cycle
      r   = sys_rsp;
    end
    @(posedge adc_clk);
    sys_req.wen <= 1'b0;
    sys_req.ren <= 1'b0;
    while (!got && cnt < BUS_TIMEOUT)
    begin
      @(negedge adc_clk);
      if (sys_rsp.ack)
      begin
        got = 1'b1;
        r   = sys_rsp;
      end
      cnt++;
    end
    if (!got)
    begin
      err_to++;
      $display("bus timeout: no ack for address %h", addr);
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    sys_bus_pkg::sys_rsp_t r;
    transfer(addr, data, 1'b1, r);
  endtask

  task automatic read_reg(input logic [31:0] addr, output sys_bus_pkg::sys_rsp_t r);
    transfer(addr, 32'h0, 1'b0, r);
  endtask

  task automatic drive_random(input int cycles);
    repeat (cycles)
    begin
      @(posedge adc_clk);
      rng = xorshift32(rng);
      adc_a <= rng[13:0];
      adc_b <= rng[29:16];
    end
  endtask

  // pins against the model at mid cycle where they are stable
  always @(negedge adc_clk)
  begin
    if (chk_a)
      check_pin("dac_dat_a_o", dac_a, dc_sel_a ? dc_pin_a : path_model(hist_a[3]));
    if (chk_b)
      check_pin("dac_dat_b_o", dac_b, path_model(hist_b[3]));
    for (int i = 3; i > 0; i--)
    begin
      hist_a[i] = hist_a[i-1];
      hist_b[i] = hist_b[i-1];
    end
    hist_a[0] = adc_a;  // seen 4 edges later on the pins
    hist_b[0] = adc_b;
  end

  initial
  begin
    adc_clk  = 1'b0;
    rst_n    = 1'b0;
    adc_a    = 14'h1FFF;  // zero code
    adc_b    = 14'h1FFF;
    sys_req  = '0;
    rng      = 32'h88eb;
    chk_a    = 1'b0;
    chk_b    = 1'b0;
    dc_sel_a = 1'b0;
    dc_pin_a = '0;
    err_val  = 0;
    err_to   = 0;
    repeat (3) @(posedge adc_clk);
    rst_n <= 1'b1;
    @(negedge adc_clk);
    check_pin("dac_dat_a_o", dac_a, 14'h1FFF);  // formatted zero
    check_pin("dac_dat_b_o", dac_b, 14'h1FFF);
    check_led(led, 8'h00);
    read_reg(sys_bus_pkg::REG_ID, rsp);
    check_rsp("id read", rsp, expect_rsp(sys_bus_pkg::HK_ID, 1'b0));

    chk_a = 1'b1;  // pass-through on both channels
    chk_b = 1'b1;
    drive_random(200);

    // housekeeping readback
    write_reg(sys_bus_pkg::REG_LED, 32'h5A3C_00A5);
    check_led(led, 8'hA5);
    read_reg(sys_bus_pkg::REG_LED, rsp);
    check_rsp("led read", rsp, expect_rsp(32'h0000_00A5, 1'b0));
    write_reg(sys_bus_pkg::REG_DC_A, {18'h0, DC_A});
    write_reg(sys_bus_pkg::REG_DC_B, {18'h0, DC_B});
    read_reg(sys_bus_pkg::REG_DC_A, rsp);
    check_rsp("dc a read", rsp, expect_rsp(widen_level(DC_A), 1'b0));
    read_reg(sys_bus_pkg::REG_DC_B, rsp);
    check_rsp("dc b read", rsp, expect_rsp(widen_level(DC_B), 1'b0));

    // channel a on dc while b keeps tracking
    chk_a = 1'b0;
    write_reg(sys_bus_pkg::REG_CTRL, 32'h2);
    dc_pin_a = neg_slope(DC_A);
    n = 0;
    while (dac_a !== dc_pin_a && n < POLL_TIMEOUT)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (dac_a !== dc_pin_a)
    begin
      err_to++;
      $display("timeout: pin a never showed the dc level");
    end
    dc_sel_a = 1'b1;
    chk_a    = 1'b1;
    drive_random(50);

    // loopback with both channels on dc
    chk_a = 1'b0;
    chk_b = 1'b0;
    write_reg(sys_bus_pkg::REG_CTRL, 32'h7);
    adc_exp = {{2{DC_B[13]}}, DC_B, {2{DC_A[13]}}, DC_A};
    read_reg(sys_bus_pkg::REG_ADC, rsp);
    n = 0;
    while (rsp.rdata !== adc_exp && n < POLL_TIMEOUT)
    begin
      read_reg(sys_bus_pkg::REG_ADC, rsp);
      n++;
    end
    check_rsp("adc readback", rsp, expect_rsp(adc_exp, 1'b0));

    // decode corners
    read_reg(32'h0050_0000, rsp);  // unused region 5
    check_rsp("region 5 read", rsp, expect_rsp(32'h0, 1'b0));
    read_reg(32'h0000_0018, rsp);  // past the last register
    check_rsp("undefined offset read", rsp, expect_rsp(32'h0, 1'b1));

    $display("errors: %0d value mismatches, %0d timeouts", err_val, err_to);
    if (err_val == 0 && err_to == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
